/* verilog/tdi_pixel_pkg.sv */
package tdi_pixel_pkg;

    // one pixel sample from the sensor
    localparam int PIXEL_W = 10;

    // each pixel rides in a 16 bit lane slot
    localparam int LANE_W  = 16;     // upper 6 bits stay zero
    localparam int LANES   = 32;     // pixels per beat

    // full beat as seen on the stream and DMA side
    localparam int BEAT_W  = LANES * LANE_W;

    typedef logic [PIXEL_W-1:0] pixel_t;   // ramp value, wraps at 1024

    // lane 0 sits in bits [15:0]
    typedef logic [BEAT_W-1:0]  beat_t;

    // lane slot helper for the ramp builder
    typedef logic [LANE_W-1:0]  lane_t;

endpackage

/* verilog/tdi_ctrl_pkg.sv */
package tdi_ctrl_pkg;

    // width of line, period and rate counts
    localparam int CNT_W = 32;

    typedef logic [CNT_W-1:0] line_cnt_t;

    // burst sequencer modes
    typedef enum logic [1:0] {
        BURST_IDLE,      // waiting for trigger or max-speed
        BURST_LINE,      // one burst per trigger
        BURST_MAX        // back to back bursts
    } burst_state_t;

endpackage

/* verilog/tdi_stream_if.sv */
interface tdi_stream_if import tdi_pixel_pkg::*; ();

    beat_t tdata;      // 32 lanes of pixels
    logic  tvalid;
    logic  tready;
    logic  tlast;      // final beat of a burst

    // beat producer
    modport src (
        output tdata,
        output tvalid,
        output tlast,
        input  tready
    );

    // beat consumer
    modport snk (
        input  tdata,
        input  tvalid,
        input  tlast,
        output tready
    );

    // passive observer, e.g. rate counting
    modport mon (
        input tdata,
        input tvalid,
        input tready,
        input tlast
    );

endinterface

/* verilog/line_trigger_gen.sv */
module line_trigger_gen import tdi_ctrl_pkg::*; #(
    parameter int TRIG_PERIOD = 200
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      i_sim_start,
    input  logic      i_sim_start_auto,
    input  line_cnt_t i_valid_lines,
    input  line_cnt_t i_total_lines,
    output logic      o_trigger,
    output logic      o_track_last
);

    localparam line_cnt_t PERIOD_LAST = line_cnt_t'(TRIG_PERIOD - 1);

    logic      start_d;       // i_sim_start one cycle late
    logic      start_pos;
    logic      track_en;
    logic      period_wrap;
    line_cnt_t period_cnt;
    line_cnt_t trig_num;      // triggers issued this track
    line_cnt_t wrap_num;      // line slots elapsed this track

    assign start_pos   = i_sim_start && !start_d;
    assign period_wrap = track_en && (period_cnt == PERIOD_LAST);

    // only the first valid_lines slots carry a trigger
    assign o_trigger    = period_wrap && (trig_num < i_valid_lines);
    assign o_track_last = track_en && (wrap_num == i_total_lines);   // ends the track

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            start_d <= 1'b0;
        else
            start_d <= i_sim_start;
    end

    // auto start keeps re-arming the track
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            track_en <= 1'b0;
        else if (i_sim_start_auto || start_pos)
            track_en <= 1'b1;
        else if (o_track_last)
            track_en <= 1'b0;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            period_cnt <= '0;
        else if (!track_en || o_track_last || period_wrap)
            period_cnt <= '0;                    // restart line slot
        else
            period_cnt <= period_cnt + 1'b1;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            trig_num <= '0;
            wrap_num <= '0;
        end
        else if (o_track_last)
        begin
            trig_num <= '0;
            wrap_num <= '0;
        end
        else
        begin
            if (o_trigger)
                trig_num <= trig_num + 1'b1;
            if (period_wrap)
                wrap_num <= wrap_num + 1'b1;
        end
    end

    // a trigger needs a full period of enabled track behind it
    trig_in_track: assert property (@(posedge clk) disable iff (rst)
        o_trigger |-> $past(track_en, TRIG_PERIOD - 1));

endmodule

/* verilog/line_burst_ctrl.sv */
module line_burst_ctrl import tdi_pixel_pkg::*, tdi_ctrl_pkg::*; #(
    parameter int CH0_LEN = 8,
    parameter int CH1_LEN = 6
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      i_trigger,
    input  logic      i_max_speed,
    input  logic      i_db_write_enable,
    tdi_stream_if.src ch0,
    tdi_stream_if.src ch1
);

    localparam int              BC_W  = $clog2(CH0_LEN + 1);
    localparam logic [BC_W-1:0] LEN0  = BC_W'(CH0_LEN);
    localparam logic [BC_W-1:0] LEN1  = BC_W'(CH1_LEN);
    localparam logic [BC_W-1:0] LAST0 = BC_W'(CH0_LEN - 1);
    localparam logic [BC_W-1:0] LAST1 = BC_W'(CH1_LEN - 1);

    burst_state_t    state;
    burst_state_t    state_nxt;
    logic [BC_W-1:0] beat_cnt;     // shared by both channels
    logic            acc0;         // ch0 beat taken, waiting on ch1
    logic            acc1;         // ch1 beat taken, waiting on ch0
    logic            xfer0;
    logic            xfer1;
    logic            adv;
    logic            burst_end;
    logic            between;      // no burst in flight
    logic            active;
    pixel_t          base0;
    pixel_t          base1;

    // lane i = base + i, low 10 bits only
    function automatic beat_t ramp_beat(input pixel_t base);
        beat_t  b;
        pixel_t p;
        b = '0;
        for (int i = 0; i < LANES; i++)
        begin
            p = base + pixel_t'(i);                  // wraps at 1024
            b[i*LANE_W +: LANE_W] = lane_t'(p);
        end
        return b;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // beat presentation
    ////////////////////////////////////////////////////////////////////////////

    assign between = (beat_cnt == '0) && !acc0 && !acc1;

    // max mode never opens a fresh burst once max-speed has dropped
    assign active = (state == BURST_LINE) ||
                    ((state == BURST_MAX) && i_db_write_enable && (i_max_speed || !between));

    assign ch0.tvalid = active && !acc0 && (beat_cnt < LEN0);
    assign ch1.tvalid = active && !acc1 && (beat_cnt < LEN1);   // own length, not ch0's
    assign ch0.tlast  = (beat_cnt == LAST0);
    assign ch1.tlast  = (beat_cnt == LAST1);
    assign ch0.tdata  = ramp_beat(base0);
    assign ch1.tdata  = ramp_beat(base1);

    assign xfer0 = ch0.tvalid && ch0.tready;
    assign xfer1 = ch1.tvalid && ch1.tready;

    // step once every channel with a beat at this index has taken it
    assign adv       = active && (acc0 || xfer0) && (acc1 || xfer1 || (beat_cnt >= LEN1));
    assign burst_end = adv && (beat_cnt == LAST0);

    ////////////////////////////////////////////////////////////////////////////
    // mode FSM
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        state_nxt = state;
        case (state)
            BURST_IDLE:
                if (i_trigger)
                    state_nxt = BURST_LINE;
                else if (i_max_speed)
                    state_nxt = BURST_MAX;
            BURST_LINE:
                if (burst_end)
                    state_nxt = BURST_IDLE;
            BURST_MAX:
                if (!i_max_speed && between)     // finish any open burst first
                    state_nxt = BURST_IDLE;
            default:
                state_nxt = BURST_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state    <= BURST_IDLE;
            beat_cnt <= '0;
            acc0     <= 1'b0;
            acc1     <= 1'b0;
        end
        else
        begin
            state <= state_nxt;
            if (adv)
                beat_cnt <= (beat_cnt == LAST0) ? '0 : beat_cnt + 1'b1;
            acc0 <= adv ? 1'b0 : (acc0 || xfer0);
            acc1 <= adv ? 1'b0 : (acc1 || xfer1);
        end
    end

    // ramp bases move on each channel's own handshake
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            base0 <= '0;
            base1 <= '0;
        end
        else
        begin
            if (xfer0)
                base0 <= ch0.tlast ? '0 : base0 + pixel_t'(LANES);
            if (xfer1)
                base1 <= ch1.tlast ? '0 : base1 + pixel_t'(LANES);
        end
    end

    // stalled beats keep their payload until taken
    hold_ch0: assert property (@(posedge clk) disable iff (rst)
        ch0.tvalid && !ch0.tready |=> $stable(ch0.tdata) && $stable(ch0.tlast));
    hold_ch1: assert property (@(posedge clk) disable iff (rst)
        ch1.tvalid && !ch1.tready |=> $stable(ch1.tdata) && $stable(ch1.tlast));

endmodule

/* verilog/line_fifo.sv */
module line_fifo import tdi_pixel_pkg::*; #(
    parameter int FIFO_DEPTH       = 32,
    parameter int PROG_FULL_THRESH = 24
) (
    input  logic      clk,
    input  logic      rst,
    tdi_stream_if.snk s,
    output beat_t     o_data,
    output logic      o_valid,
    output logic      o_last,
    output logic      o_prog_full,
    input  logic      i_ready
);

    localparam int            AW       = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int            CW       = $clog2(FIFO_DEPTH + 1);
    localparam logic [AW-1:0] PTR_LAST = AW'(FIFO_DEPTH - 1);
    localparam logic [CW-1:0] FULL_CNT = CW'(FIFO_DEPTH);
    localparam logic [CW-1:0] PF_CNT   = CW'(PROG_FULL_THRESH);

    logic [BEAT_W:0] mem [FIFO_DEPTH];    // {last, beat}
    logic [AW-1:0]   wr_ptr;
    logic [AW-1:0]   rd_ptr;
    logic [CW-1:0]   count;               // beats held
    logic            wr;
    logic            rd;

    assign s.tready    = (count != FULL_CNT);     // back-pressure only when full
    assign o_valid     = (count != '0);
    assign o_prog_full = (count >= PF_CNT);
    assign {o_last, o_data} = mem[rd_ptr];        // show-ahead read

    assign wr = s.tvalid && s.tready;
    assign rd = o_valid && i_ready;

    always_ff @(posedge clk)
    begin
        if (wr)
            mem[wr_ptr] <= {s.tlast, s.tdata};
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (wr)
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            if (rd)
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            case ({wr, rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;         // none or both
            endcase
        end
    end

    // overrun pushes the count past depth, underrun wraps it past depth
    no_wr_full: assert property (@(posedge clk) disable iff (rst)
        count <= FULL_CNT);
    // pointers meet only when empty or full
    no_rd_empty: assert property (@(posedge clk) disable iff (rst)
        (wr_ptr == rd_ptr) == ((count == '0) || (count == FULL_CNT)));

endmodule

/* verilog/rate_monitor.sv */
module rate_monitor import tdi_ctrl_pkg::*; #(
    parameter int CLKS_PER_WIN = 200_000_000
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      i_max_speed,
    tdi_stream_if.mon m,
    output line_cnt_t o_bursts_per_win
);

    localparam line_cnt_t WIN_LAST = line_cnt_t'(CLKS_PER_WIN - 1);

    logic      max_d;
    logic      max_rise;      // window realigns here
    logic      win_end;
    logic      burst_done;    // ch0 last beat taken in max mode
    line_cnt_t win_cnt;
    line_cnt_t burst_cnt;

    assign max_rise   = i_max_speed && !max_d;
    assign win_end    = (win_cnt == WIN_LAST);
    assign burst_done = i_max_speed && m.tvalid && m.tready && m.tlast;

    // window keeps running after max-speed ends so the rate falls to 0
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            max_d            <= 1'b0;
            win_cnt          <= '0;
            burst_cnt        <= '0;
            o_bursts_per_win <= '0;
        end
        else
        begin
            max_d <= i_max_speed;
            if (max_rise || win_end)
                win_cnt <= '0;
            else
                win_cnt <= win_cnt + 1'b1;
            if (max_rise || win_end)
                burst_cnt <= line_cnt_t'(burst_done);
            else if (burst_done)
                burst_cnt <= burst_cnt + 1'b1;
            if (win_end)
                o_bursts_per_win <= burst_cnt + line_cnt_t'(burst_done);   // include edge beat
        end
    end

endmodule

/* verilog/tdi_data_sim.sv */
module tdi_data_sim import tdi_pixel_pkg::*, tdi_ctrl_pkg::*; #(
    parameter int TRIG_PERIOD      = 200,
    parameter int CH0_LEN          = 8,
    parameter int CH1_LEN          = 6,           // not above CH0_LEN
    parameter int FIFO_DEPTH       = 32,
    parameter int PROG_FULL_THRESH = 24,
    parameter int CLKS_PER_WIN     = 200_000_000
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      i_sim_start,
    input  logic      i_sim_start_auto,
    input  logic      i_db_write_enable,
    input  logic      i_max_speed,
    input  line_cnt_t i_valid_lines,
    input  line_cnt_t i_total_lines,
    output logic      o_trigger,
    output logic      o_track_last,
    input  logic      i_dma_ready_0,
    output beat_t     o_dma_data_0,
    output logic      o_dma_valid_0,
    output logic      o_dma_last_0,
    output logic      o_fifo_full_0,
    input  logic      i_dma_ready_1,
    output beat_t     o_dma_data_1,
    output logic      o_dma_valid_1,
    output logic      o_dma_last_1,
    output logic      o_fifo_full_1,
    output line_cnt_t o_bursts_per_win
);

    ////////////////////////////////////////////////////////////////////////////
    // line timing and burst generation
    ////////////////////////////////////////////////////////////////////////////

    tdi_stream_if link_ch0 ();    // ctrl -> fifo_ch0, watched by monitor
    tdi_stream_if link_ch1 ();    // ctrl -> fifo_ch1

    line_trigger_gen #(.TRIG_PERIOD(TRIG_PERIOD)) u_trig (
        .clk              (clk),
        .rst              (rst),
        .i_sim_start      (i_sim_start),
        .i_sim_start_auto (i_sim_start_auto),
        .i_valid_lines    (i_valid_lines),
        .i_total_lines    (i_total_lines),
        .o_trigger        (o_trigger),
        .o_track_last     (o_track_last)
    );

    line_burst_ctrl #(.CH0_LEN(CH0_LEN), .CH1_LEN(CH1_LEN)) u_burst (
        .clk               (clk),
        .rst               (rst),
        .i_trigger         (o_trigger),
        .i_max_speed       (i_max_speed),
        .i_db_write_enable (i_db_write_enable),
        .ch0               (link_ch0.src),
        .ch1               (link_ch1.src)
    );

    ////////////////////////////////////////////////////////////////////////////
    // per-channel buffering towards DMA
    ////////////////////////////////////////////////////////////////////////////

    line_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .PROG_FULL_THRESH(PROG_FULL_THRESH)) fifo_ch0 (
        .clk         (clk),
        .rst         (rst),
        .s           (link_ch0.snk),
        .o_data      (o_dma_data_0),
        .o_valid     (o_dma_valid_0),
        .o_last      (o_dma_last_0),
        .o_prog_full (o_fifo_full_0),
        .i_ready     (i_dma_ready_0)
    );

    line_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .PROG_FULL_THRESH(PROG_FULL_THRESH)) fifo_ch1 (
        .clk         (clk),
        .rst         (rst),
        .s           (link_ch1.snk),
        .o_data      (o_dma_data_1),
        .o_valid     (o_dma_valid_1),
        .o_last      (o_dma_last_1),
        .o_prog_full (o_fifo_full_1),
        .i_ready     (i_dma_ready_1)
    );

    // max-speed throughput, ch0 bursts only
    rate_monitor #(.CLKS_PER_WIN(CLKS_PER_WIN)) u_rate (
        .clk              (clk),
        .rst              (rst),
        .i_max_speed      (i_max_speed),
        .m                (link_ch0.mon),
        .o_bursts_per_win (o_bursts_per_win)
    );

endmodule

/* verification/tdi_checker.sv */
module tdi_checker import tdi_pixel_pkg::*, tdi_ctrl_pkg::*; #(
    parameter int CH0_LEN          = 8,
    parameter int CH1_LEN          = 6,
    parameter int PROG_FULL_THRESH = 24
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      i_trigger,
    input  logic      i_track_last,
    input  beat_t     i_data_0,
    input  logic      i_valid_0,
    input  logic      i_last_0,
    input  logic      i_ready_0,
    input  logic      i_full_0,
    input  logic      i_wr_0,         // beat written into fifo_ch0
    input  beat_t     i_data_1,
    input  logic      i_valid_1,
    input  logic      i_last_1,
    input  logic      i_ready_1,
    input  logic      i_full_1,
    input  logic      i_wr_1,
    input  line_cnt_t i_rate,
    input  logic      i_case_start,
    input  logic      i_case_end,
    input  logic      i_chk_pkts,     // line mode only
    input  logic      i_chk_full,
    input  logic      i_chk_rate,
    input  int        i_exp_trig,
    input  int        i_exp_track,
    input  int        i_exp_pkt0,
    input  int        i_exp_pkt1,
    input  line_cnt_t i_rate_exp,
    input  line_cnt_t i_rate_tol,
    output int        o_err_cnt
);
    timeunit 1ns;
    timeprecision 1ps;

    int   beat_k [2];      // beat index inside current packet
    int   pkts [2];        // packets this case
    int   wr_cnt [2];
    int   rd_cnt [2];
    int   trig_cnt;
    int   track_cnt;
    logic rst_seen;

    initial
    begin
        o_err_cnt = 0;
        rst_seen  = 1'b0;
        trig_cnt  = 0;
        track_cnt = 0;
        for (int c = 0; c < 2; c++)
        begin
            beat_k[c] = 0;
            pkts[c]   = 0;
            wr_cnt[c] = 0;
            rd_cnt[c] = 0;
        end
    end

    task automatic flag_error(input string msg);
        o_err_cnt++;
        $display("ERR %0t: %s", $time, msg);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // per-beat ramp and framing
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_beat(input int ch, input beat_t d, input logic last);
        int    len;
        lane_t got;
        lane_t exp;
        logic  bad;
        len = (ch == 0) ? CH0_LEN : CH1_LEN;
        bad = 1'b0;
        for (int i = 0; i < LANES; i++)
        begin
            got = d[i*LANE_W +: LANE_W];
            exp = lane_t'((beat_k[ch] * LANES + i) % (1 << PIXEL_W));   // upper bits zero
            if (!bad && got !== exp)
            begin
                bad = 1'b1;                          // one report per beat
                flag_error($sformatf("ch%0d beat %0d lane %0d got %h exp %h",
                                     ch, beat_k[ch], i, got, exp));
            end
        end
        if (last !== (beat_k[ch] == len - 1))
            flag_error($sformatf("ch%0d last=%b on beat %0d", ch, last, beat_k[ch]));
        if (last || beat_k[ch] == len - 1)
        begin
            pkts[ch]++;
            beat_k[ch] = 0;    // resync on either marker
        end
        else
            beat_k[ch]++;
    endtask

    task automatic check_full(input int ch, input logic flag);
        int occ;
        occ = wr_cnt[ch] - rd_cnt[ch];
        if (flag !== (occ >= PROG_FULL_THRESH))
            flag_error($sformatf("ch%0d full flag %b with %0d beats held", ch, flag, occ));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // sampled on the edge, before this edge's transfers are counted
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk)
    begin
        if (rst)
        begin
            if (rst_seen && (i_trigger || i_track_last || i_valid_0 || i_valid_1 ||
                             i_full_0 || i_full_1 || i_rate != '0))
                flag_error("outputs not idle in reset");
            rst_seen = 1'b1;
        end
        else
        begin
            if (i_chk_full)
            begin
                check_full(0, i_full_0);
                check_full(1, i_full_1);
            end
            if (i_chk_rate)
            begin
                if (((i_rate > i_rate_exp) ? i_rate - i_rate_exp : i_rate_exp - i_rate)
                    > i_rate_tol)
                    flag_error($sformatf("rate %0d exp %0d", i_rate, i_rate_exp));
            end
            if (i_case_end)
            begin
                if (trig_cnt != i_exp_trig)
                    flag_error($sformatf("triggers %0d exp %0d", trig_cnt, i_exp_trig));
                if (track_cnt != i_exp_track)
                    flag_error($sformatf("track ends %0d exp %0d", track_cnt, i_exp_track));
                if (i_chk_pkts && pkts[0] != i_exp_pkt0)
                    flag_error($sformatf("ch0 packets %0d exp %0d", pkts[0], i_exp_pkt0));
                if (i_chk_pkts && pkts[1] != i_exp_pkt1)
                    flag_error($sformatf("ch1 packets %0d exp %0d", pkts[1], i_exp_pkt1));
                if (beat_k[0] != 0 || beat_k[1] != 0)
                    flag_error("packet left open at case end");
            end
            if (i_case_start)
            begin
                trig_cnt  = 0;
                track_cnt = 0;
                pkts[0]   = 0;
                pkts[1]   = 0;
            end
            if (i_trigger)
                trig_cnt++;
            if (i_track_last)
                track_cnt++;
            if (i_valid_0 && i_ready_0)
            begin
                check_beat(0, i_data_0, i_last_0);
                rd_cnt[0]++;
            end
            if (i_valid_1 && i_ready_1)
            begin
                check_beat(1, i_data_1, i_last_1);
                rd_cnt[1]++;
            end
            if (i_wr_0)
                wr_cnt[0]++;
            if (i_wr_1)
                wr_cnt[1]++;
        end
    end

endmodule

/* verification/tdi_data_sim_tb.sv */
module tdi_data_sim_tb import tdi_pixel_pkg::*, tdi_ctrl_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TRIG_PERIOD      = 20;
    localparam int CH0_LEN          = 8;
    localparam int CH1_LEN          = 6;
    localparam int FIFO_DEPTH       = 32;
    localparam int PROG_FULL_THRESH = 24;
    localparam int CLKS_PER_WIN     = 400;
    localparam int RDY_RANDOM       = 1;
    localparam int RDY_STALL        = 2;

    logic clk, rst;
    logic i_sim_start, i_sim_start_auto, i_db_write_enable, i_max_speed;
    line_cnt_t i_valid_lines, i_total_lines, o_bursts_per_win, rate_exp, rate_tol;
    logic o_trigger, o_track_last;
    logic i_dma_ready_0, o_dma_valid_0, o_dma_last_0, o_fifo_full_0, wr_0;
    logic i_dma_ready_1, o_dma_valid_1, o_dma_last_1, o_fifo_full_1, wr_1;
    beat_t o_dma_data_0, o_dma_data_1;
    logic case_start, case_end, chk_pkts, chk_full, chk_rate;
    int exp_trig, exp_track, exp_pkt0, exp_pkt1, err_cnt;
    int rdy_mode, stall_n, case_cyc, other_err, limit, cyc;
    integer seed;
    integer r0, r1;
    logic [31:0] gold [0:255];    // see golden file header

    tdi_data_sim #(.TRIG_PERIOD(TRIG_PERIOD), .CH0_LEN(CH0_LEN), .CH1_LEN(CH1_LEN),
        .FIFO_DEPTH(FIFO_DEPTH), .PROG_FULL_THRESH(PROG_FULL_THRESH),
        .CLKS_PER_WIN(CLKS_PER_WIN)) uut (.*);

    // fifo write side is internal, seen through the link
    assign wr_0 = uut.link_ch0.tvalid && uut.link_ch0.tready;
    assign wr_1 = uut.link_ch1.tvalid && uut.link_ch1.tready;

    tdi_checker #(.CH0_LEN(CH0_LEN), .CH1_LEN(CH1_LEN),
        .PROG_FULL_THRESH(PROG_FULL_THRESH)) u_chk (
        .clk(clk), .rst(rst), .i_trigger(o_trigger), .i_track_last(o_track_last),
        .i_data_0(o_dma_data_0), .i_valid_0(o_dma_valid_0), .i_last_0(o_dma_last_0),
        .i_ready_0(i_dma_ready_0), .i_full_0(o_fifo_full_0), .i_wr_0(wr_0),
        .i_data_1(o_dma_data_1), .i_valid_1(o_dma_valid_1), .i_last_1(o_dma_last_1),
        .i_ready_1(i_dma_ready_1), .i_full_1(o_fifo_full_1), .i_wr_1(wr_1),
        .i_rate(o_bursts_per_win), .i_case_start(case_start), .i_case_end(case_end),
        .i_chk_pkts(chk_pkts), .i_chk_full(chk_full), .i_chk_rate(chk_rate),
        .i_exp_trig(exp_trig), .i_exp_track(exp_track), .i_exp_pkt0(exp_pkt0),
        .i_exp_pkt1(exp_pkt1), .i_rate_exp(rate_exp), .i_rate_tol(rate_tol),
        .o_err_cnt(err_cnt));

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // dma ready pattern, low for stall_n cycles after case start in stall mode
    always @(posedge clk)
    begin
        case_cyc <= case_start ? 0 : case_cyc + 1;
        chk_full <= (rdy_mode == RDY_STALL) && (case_cyc == stall_n);
        if (rdy_mode == RDY_RANDOM)
        begin
            r0 = $random(seed);
            r1 = $random(seed);
            i_dma_ready_0 <= r0[0];
            i_dma_ready_1 <= r1[0];
        end
        else
        begin
            i_dma_ready_0 <= !((rdy_mode == RDY_STALL) && (case_cyc < stall_n));
            i_dma_ready_1 <= !((rdy_mode == RDY_STALL) && (case_cyc < stall_n));
        end
    end

    // run limit
    always @(posedge clk)
    begin
        cyc <= cyc + 1;
        if (limit != 0 && cyc >= limit)
        begin
            $display("timeout: run passed its limit of %0d cycles", limit);
            $display("errors: checker %0d, other %0d", err_cnt, other_err + 1);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic run_track();
        i_sim_start <= 1'b1;
        @(posedge clk);
        i_sim_start <= 1'b0;
        while (!o_track_last)
            @(posedge clk);
    endtask

    task automatic run_max(input int windows, input int rate);
        i_max_speed       <= 1'b1;
        i_db_write_enable <= 1'b1;
        repeat (CLKS_PER_WIN + 4) @(posedge clk);    // first latch lands 401 after
        for (int w = 0; w < windows; w++)
        begin
            rate_exp <= line_cnt_t'(rate);
            rate_tol <= 1;
            chk_rate <= 1'b1;
            @(posedge clk);
            chk_rate <= 1'b0;
            repeat (CLKS_PER_WIN - 1) @(posedge clk);
        end
        i_max_speed <= 1'b0;                           // open burst still completes
        repeat (2 * CLKS_PER_WIN + 4) @(posedge clk);
        rate_exp <= '0;
        rate_tol <= '0;
        chk_rate <= 1'b1;
        @(posedge clk);
        chk_rate          <= 1'b0;
        i_db_write_enable <= 1'b0;
    endtask

    // both fifos empty for a while
    task automatic wait_drain();
        int idle;
        idle = 0;
        while (idle < 24)
        begin
            @(posedge clk);
            idle = (o_dma_valid_0 || o_dma_valid_1) ? 0 : idle + 1;
        end
    endtask

    initial
    begin
        int ncase;
        int b;
        int vl;
        int tl;
        logic line_mode;
        seed = 32'h33a1_4e3a;
        rst = 1'b1;
        i_sim_start = 1'b0;
        i_sim_start_auto = 1'b0;
        i_db_write_enable = 1'b0;
        i_max_speed = 1'b0;
        i_valid_lines = '0;
        i_total_lines = '0;
        i_dma_ready_0 = 1'b1;
        i_dma_ready_1 = 1'b1;
        {case_start, case_end, chk_pkts, chk_full, chk_rate} = '0;
        {exp_trig, exp_track, exp_pkt0, exp_pkt1} = '0;
        rate_exp = '0;
        rate_tol = '0;
        rdy_mode = 0;
        stall_n = 0;
        case_cyc = 0;
        other_err = 0;
        cyc = 0;
        limit = 0;
        for (int i = 0; i < 256; i++)
            gold[i] = '0;
        $readmemh("verification/tdi_golden_cases.txt", gold);
        ncase = gold[0];
        if ($isunknown(gold[0]) || ncase == 0 || ncase > 31)
        begin
            $display("golden case file is missing, empty or too long");
            other_err++;
            ncase = 0;
        end
        for (int c = 0; c < ncase; c++)
            limit += 2 * (gold[1 + c*8 + 3] * TRIG_PERIOD + 3 * CLKS_PER_WIN);
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        for (int c = 0; c < ncase; c++)
        begin
            b         = 1 + c*8;
            line_mode = (gold[b+1] == 0);
            vl        = gold[b+2];
            tl        = gold[b+3];
            @(posedge clk);
            i_valid_lines <= line_cnt_t'(vl);
            i_total_lines <= line_cnt_t'(tl);
            rdy_mode      <= gold[b+4];
            stall_n       <= gold[b+5];
            exp_trig      <= line_mode ? ((vl < tl) ? vl : tl) : 0;   // min of the two
            exp_track     <= line_mode ? 1 : 0;
            exp_pkt0      <= gold[b+6];
            exp_pkt1      <= gold[b+7];
            chk_pkts      <= line_mode;
            case_start    <= 1'b1;
            @(posedge clk);
            case_start <= 1'b0;
            if (line_mode)
                run_track();
            else
                run_max(vl, gold[b+6]);
            wait_drain();
            case_end <= 1'b1;
            @(posedge clk);
            case_end <= 1'b0;
            @(posedge clk);
            $display("case %0d finished at cycle %0d", gold[b], cyc);
        end
        $display("errors: checker %0d, other %0d", err_cnt, other_err);
        if (err_cnt == 0 && other_err == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

/* src.f */
verilog/tdi_pixel_pkg.sv
verilog/tdi_ctrl_pkg.sv
verilog/tdi_stream_if.sv
verilog/line_trigger_gen.sv
verilog/line_burst_ctrl.sv
verilog/line_fifo.sv
verilog/rate_monitor.sv
verilog/tdi_data_sim.sv
verification/tdi_checker.sv
verification/tdi_data_sim_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tdi_data_sim_tb -f src.f -o tdi_sim

./obj_dir/tdi_sim | tee sim.log

if grep -q "\*\* FAIL \*\*" sim.log; then
    exit 1
fi
grep -q "\*\* PASS \*\*" sim.log

/* verification/tdi_golden_cases.txt */
// first word: number of cases, then one case per line, all hex
// id mode(0 line, 1 max) valid_lines total_lines ready(0 always, 1 random, 2 stall)
//    stall_cycles exp_ch0 exp_ch1 ; max mode: valid_lines = windows, exp_ch0 = rate
6
1 0 4 6 0 0  4 4
2 0 8 5 0 0  5 5
3 0 6 8 1 0  6 6
4 0 5 7 2 5a 5 5
5 1 3 0 0 0  32 0
6 0 3 3 1 0  3 3
